//--- design/bkt_pkg.sv
//==========================================================================
// Backtrack engine package
// Widths, command opcodes and the structs shared by FIFO, finder and RAM
//==========================================================================
package bkt_pkg;

    localparam int LVL_W     = 4;                // Decision level, also RAM address
    localparam int BIN_W     = 8;                // Variable id
    localparam int LVL_DEPTH = 16;               // One state word per level
    localparam int CMD_DEPTH = 2;                // Command FIFO entries

    localparam int CMD_PTR_W = $clog2(CMD_DEPTH);
    localparam int CMD_CNT_W = $clog2(CMD_DEPTH + 1);

    typedef enum logic
    {
        OP_PUSH = 1'b0,                          // Record decision, clear has_bkt
        OP_FIND = 1'b1                           // Downward scan for unflipped level
    } bkt_op_e;

    // Host command, bin unused for FIND
    typedef struct packed
    {
        bkt_op_e            op;
        logic [LVL_W-1:0]   lvl;
        logic [BIN_W-1:0]   bin;
    } bkt_cmd_t;

    // RAM word, bin in the upper bits
    typedef struct packed
    {
        logic [BIN_W-1:0]   bin;
        logic               has_bkt;             // Decision already flipped
    } lvl_state_t;

    // FIND result, found low means UNSAT
    typedef struct packed
    {
        logic               found;
        logic [LVL_W-1:0]   lvl;
        logic [BIN_W-1:0]   bin;
    } bkt_res_t;

endpackage

//--- design/bkt_cmd_fifo.sv
//==========================================================================
// Command FIFO
// Two-entry valid/ready buffer between host and backtrack finder
//==========================================================================
module bkt_cmd_fifo
    import bkt_pkg::*;
(
    input  logic        clk,
    input  logic        rst,

    input  logic        in_valid_i,
    output logic        in_ready_o,
    input  bkt_cmd_t    in_cmd_i,

    output logic        out_valid_o,
    input  logic        out_ready_i,
    output bkt_cmd_t    out_cmd_o
);

    bkt_cmd_t               mem [CMD_DEPTH];
    logic [CMD_PTR_W-1:0]   wr_ptr;
    logic [CMD_PTR_W-1:0]   rd_ptr;
    logic [CMD_CNT_W-1:0]   count;
    logic                   push;
    logic                   pop;

    function automatic logic [CMD_PTR_W-1:0] ptr_next(input logic [CMD_PTR_W-1:0] ptr);
        logic [CMD_PTR_W-1:0] nxt;
        if (ptr == CMD_PTR_W'(CMD_DEPTH - 1))
            nxt = '0;
        else
            nxt = ptr + 1'b1;
        return nxt;
    endfunction

    assign in_ready_o  = (count != CMD_CNT_W'(CMD_DEPTH));  // Stall host when full
    assign out_valid_o = (count != '0);
    assign out_cmd_o   = mem[rd_ptr];                        // Oldest entry

    assign push = in_valid_i && in_ready_o;
    assign pop  = out_valid_o && out_ready_i;

    always_ff @(posedge clk)
    begin
        if (push)
            mem[wr_ptr] <= in_cmd_i;
    end

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= ptr_next(wr_ptr);
            if (pop)
                rd_ptr <= ptr_next(rd_ptr);
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;             // Both or neither
            endcase
        end
    end

endmodule

//--- design/lvl_state_ram.sv
//==========================================================================
// Level-state memory
// One word per decision level, registered read and single write port
//==========================================================================
module lvl_state_ram
    import bkt_pkg::*;
(
    input  logic                clk,

    input  logic [LVL_W-1:0]    rd_addr_i,
    output lvl_state_t          rd_data_o,

    input  logic                wr_en_i,
    input  logic [LVL_W-1:0]    wr_addr_i,
    input  lvl_state_t          wr_data_i
);

    lvl_state_t mem [LVL_DEPTH];

    always_ff @(posedge clk)
    begin
        if (wr_en_i)
            mem[wr_addr_i] <= wr_data_i;
    end

    // Data follows the address by one cycle
    always_ff @(posedge clk)
    begin
        rd_data_o <= mem[rd_addr_i];
    end

endmodule

//--- design/bkt_lvl_finder.sv
//==========================================================================
// Backtrack level finder
// Executes PUSH writes and FIND scans, marks the level found, holds result
//==========================================================================
module bkt_lvl_finder
    import bkt_pkg::*;
(
    input  logic                clk,
    input  logic                rst,

    input  logic                cmd_valid_i,
    output logic                cmd_ready_o,
    input  bkt_cmd_t            cmd_i,

    output logic [LVL_W-1:0]    rd_addr_o,
    input  lvl_state_t          rd_data_i,

    output logic                wr_en_o,
    output logic [LVL_W-1:0]    wr_addr_o,
    output lvl_state_t          wr_data_o,

    output logic                res_valid_o,
    input  logic                res_ready_i,
    output bkt_res_t            res_o
);

    typedef enum logic [2:0]
    {
        IDLE,
        READ,                                    // Address on RAM read port
        CHECK,                                   // Test returned word
        MARK,                                    // Write back with has_bkt set
        RESP                                     // Wait for host to take result
    } find_state_e;

    find_state_e        state;
    logic [LVL_W-1:0]   lvl_cnt;
    bkt_res_t           res_q;
    logic               accept;
    logic               push_go;
    logic               find_go;
    logic               hit;
    logic               last_lvl;

    assign cmd_ready_o = (state == IDLE);
    assign accept      = cmd_valid_i && cmd_ready_o;
    assign push_go     = accept && (cmd_i.op == OP_PUSH);
    assign find_go     = accept && (cmd_i.op == OP_FIND);

    assign hit      = (state == CHECK) && !rd_data_i.has_bkt;
    assign last_lvl = (lvl_cnt == LVL_W'(1));    // Level 0 is root, never read

    assign rd_addr_o   = lvl_cnt;
    assign res_valid_o = (state == RESP);
    assign res_o       = res_q;

    always_ff @(posedge clk)
    begin
        if (!rst)
            state <= IDLE;
        else
        begin
            case (state)
                IDLE:
                begin
                    if (find_go)
                        state <= (cmd_i.lvl == '0) ? RESP : READ;
                end
                READ:
                    state <= CHECK;
                CHECK:
                begin
                    if (!rd_data_i.has_bkt)
                        state <= MARK;
                    else if (last_lvl)
                        state <= RESP;           // All flipped, UNSAT
                    else
                        state <= READ;
                end
                MARK:
                    state <= RESP;
                RESP:
                begin
                    if (res_ready_i)
                        state <= IDLE;
                end
                default:
                    state <= IDLE;
            endcase
        end
    end

    // Scan walks down one level per READ/CHECK pair
    always_ff @(posedge clk)
    begin
        if (find_go)
            lvl_cnt <= cmd_i.lvl;
        else if (state == CHECK && rd_data_i.has_bkt && !last_lvl)
            lvl_cnt <= lvl_cnt - 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (!rst)
            wr_en_o <= 1'b0;
        else
            wr_en_o <= push_go || hit;           // High during the cycle after, i.e. MARK
    end

    always_ff @(posedge clk)
    begin
        if (push_go)
        begin
            wr_addr_o <= cmd_i.lvl;
            wr_data_o <= '{bin: cmd_i.bin, has_bkt: 1'b0};
        end
        else if (hit)
        begin
            wr_addr_o <= lvl_cnt;
            wr_data_o <= '{bin: rd_data_i.bin, has_bkt: 1'b1};
        end
    end

    // Defaults to not found, overwritten on a hit
    always_ff @(posedge clk)
    begin
        if (find_go)
            res_q <= '0;
        else if (hit)
            res_q <= '{found: 1'b1, lvl: lvl_cnt, bin: rd_data_i.bin};
    end

endmodule

//--- design/bkt_engine_top.sv
//==========================================================================
// Backtrack engine top
// Command FIFO, level finder and level-state RAM
//==========================================================================
module bkt_engine_top
    import bkt_pkg::*;
(
    input  logic        clk,
    input  logic        rst,

    input  logic        cmd_valid_i,
    output logic        cmd_ready_o,
    input  bkt_cmd_t    cmd_i,

    output logic        res_valid_o,
    input  logic        res_ready_i,
    output bkt_res_t    res_o
);

    logic               fifo_valid;
    logic               fifo_ready;
    bkt_cmd_t           fifo_cmd;

    logic [LVL_W-1:0]   rd_addr;
    lvl_state_t         rd_data;
    logic               wr_en;
    logic [LVL_W-1:0]   wr_addr;
    lvl_state_t         wr_data;

    bkt_cmd_fifo bkt_cmd_fifo_i
    (
        .clk         (clk),
        .rst         (rst),
        .in_valid_i  (cmd_valid_i),
        .in_ready_o  (cmd_ready_o),
        .in_cmd_i    (cmd_i),
        .out_valid_o (fifo_valid),
        .out_ready_i (fifo_ready),
        .out_cmd_o   (fifo_cmd)
    );

    bkt_lvl_finder bkt_lvl_finder_i
    (
        .clk         (clk),
        .rst         (rst),
        .cmd_valid_i (fifo_valid),
        .cmd_ready_o (fifo_ready),
        .cmd_i       (fifo_cmd),
        .rd_addr_o   (rd_addr),
        .rd_data_i   (rd_data),
        .wr_en_o     (wr_en),
        .wr_addr_o   (wr_addr),
        .wr_data_o   (wr_data),
        .res_valid_o (res_valid_o),
        .res_ready_i (res_ready_i),
        .res_o       (res_o)
    );

    lvl_state_ram lvl_state_ram_i
    (
        .clk       (clk),
        .rd_addr_i (rd_addr),
        .rd_data_o (rd_data),
        .wr_en_i   (wr_en),
        .wr_addr_i (wr_addr),
        .wr_data_i (wr_data)
    );

endmodule

//--- tb/bkt_engine_tb.sv
//==========================================================================
// Backtrack engine testbench
// Table-driven PUSH/FIND sequence against a shadow level model
//==========================================================================
module bkt_engine_tb
    import bkt_pkg::*;
;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int          N_CMDS         = 22;
    localparam int          TIMEOUT_CYCLES = N_CMDS * 40 + 200;
    localparam logic [31:0] LFSR_SEED      = 32'h6a5b_7319;

    logic       clk;
    logic       rst;
    logic       cmd_valid_i;
    logic       cmd_ready_o;
    bkt_cmd_t   cmd_i;
    logic       res_valid_o;
    logic       res_ready_i;
    bkt_res_t   res_o;

    bkt_cmd_t   cmd_table [N_CMDS];
    lvl_state_t shadow [LVL_DEPTH];              // Model of the level RAM
    bkt_res_t   exp_q [$];
    int         idx_q [$];
    int         pass_cnt  = 0;
    int         fail_cnt  = 0;
    int         find_cnt  = 0;
    int         res_cnt   = 0;
    int         stall_cnt = 0;

    bkt_engine_top bkt_engine_top_i
    (
        .clk         (clk),
        .rst         (rst),
        .cmd_valid_i (cmd_valid_i),
        .cmd_ready_o (cmd_ready_o),
        .cmd_i       (cmd_i),
        .res_valid_o (res_valid_o),
        .res_ready_i (res_ready_i),
        .res_o       (res_o)
    );

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // x^32+x^22+x^2+x+1
    endfunction

    function automatic bkt_cmd_t make_cmd(input bkt_op_e op, input int lvl,
                                          input logic [BIN_W-1:0] bin);
        bkt_cmd_t c;
        c.op  = op;
        c.lvl = LVL_W'(lvl);
        c.bin = bin;
        return c;
    endfunction

    task automatic load_table();
        cmd_table[0]  = make_cmd(OP_PUSH, 1, 8'h11);
        cmd_table[1]  = make_cmd(OP_PUSH, 2, 8'h22);
        cmd_table[2]  = make_cmd(OP_PUSH, 3, 8'h33);
        cmd_table[3]  = make_cmd(OP_PUSH, 4, 8'h44);
        cmd_table[4]  = make_cmd(OP_PUSH, 5, 8'h55);
        cmd_table[5]  = make_cmd(OP_FIND, 5, 8'h00);     // Hits 5
        cmd_table[6]  = make_cmd(OP_FIND, 5, 8'h00);
        cmd_table[7]  = make_cmd(OP_FIND, 5, 8'h00);
        cmd_table[8]  = make_cmd(OP_FIND, 5, 8'h00);
        cmd_table[9]  = make_cmd(OP_FIND, 5, 8'h00);     // Hits 1
        cmd_table[10] = make_cmd(OP_FIND, 5, 8'h00);     // All flipped
        cmd_table[11] = make_cmd(OP_FIND, 0, 8'h00);     // Root only
        cmd_table[12] = make_cmd(OP_PUSH, 3, 8'ha3);
        cmd_table[13] = make_cmd(OP_FIND, 5, 8'h00);
        cmd_table[14] = make_cmd(OP_FIND, 5, 8'h00);
        cmd_table[15] = make_cmd(OP_PUSH, 6, 8'h66);
        cmd_table[16] = make_cmd(OP_PUSH, 7, 8'h77);
        cmd_table[17] = make_cmd(OP_FIND, 7, 8'h00);
        cmd_table[18] = make_cmd(OP_FIND, 7, 8'h00);
        cmd_table[19] = make_cmd(OP_FIND, 7, 8'h00);
        cmd_table[20] = make_cmd(OP_PUSH, 15, 8'hf5);    // Top address
        cmd_table[21] = make_cmd(OP_FIND, 15, 8'h00);
    endtask

    // Walk down from the start level, flip the first unflipped level
    task automatic predict_find(input bkt_cmd_t cmd, output bkt_res_t exp);
        int l;
        exp = '0;
        l   = int'(cmd.lvl);
        while (l >= 1 && !exp.found)
        begin
            if (!shadow[l].has_bkt)
            begin
                shadow[l].has_bkt = 1'b1;
                exp.found = 1'b1;
                exp.lvl   = LVL_W'(l);
                exp.bin   = shadow[l].bin;
            end
            l--;
        end
    endtask

    task automatic check_res(input bkt_res_t got, input bkt_res_t exp, output bit ok);
        ok = 1'b1;
        if (got.found !== exp.found)
        begin
            $display("[ERROR] %0d ns res_o.found: got %0b, expected %0b",
                     $time, got.found, exp.found);
            ok = 1'b0;
        end
        if (exp.found && got.lvl !== exp.lvl)
        begin
            $display("[ERROR] %0d ns res_o.lvl: got %0d, expected %0d",
                     $time, got.lvl, exp.lvl);
            ok = 1'b0;
        end
        if (exp.found && got.bin !== exp.bin)
        begin
            $display("[ERROR] %0d ns res_o.bin: got %02h, expected %02h",
                     $time, got.bin, exp.bin);
            ok = 1'b0;
        end
    endtask

    task automatic check_ready(input logic got, input logic exp, output bit ok);
        ok = (got === exp);
        if (!ok)
            $display("[ERROR] %0d ns cmd_ready_o: got %0b, expected %0b", $time, got, exp);
    endtask

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Result monitor, also drives random res_ready_i
    initial
    begin
        logic [31:0] lfsr;
        bit          hold;
        bit          ok;
        bkt_res_t    held;
        bkt_res_t    exp;
        int          idx;
        lfsr        = LFSR_SEED;
        hold        = 1'b0;
        held        = '0;
        res_ready_i = 1'b0;
        forever
        begin
            @(negedge clk);
            lfsr        = lfsr_next(lfsr);
            res_ready_i = lfsr[0];
            if (rst)
            begin
                if (hold && (res_valid_o !== 1'b1 || res_o !== held))
                begin
                    $display("Result changed or dropped at %0d ns before it was taken", $time);
                    fail_cnt++;
                end
                if (res_valid_o && res_ready_i)  // Taken at next rising edge
                begin
                    res_cnt++;
                    if (exp_q.size() == 0)
                    begin
                        $display("Unexpected result at %0d ns with no FIND pending", $time);
                        fail_cnt++;
                    end
                    else
                    begin
                        exp = exp_q.pop_front();
                        idx = idx_q.pop_front();
                        check_res(res_o, exp, ok);
                        if (ok)
                            pass_cnt++;
                        else
                            fail_cnt++;
                        $display("cmd %0d FIND from %0d: found=%0b lvl=%0d bin=%02h %s",
                                 idx, cmd_table[idx].lvl, res_o.found, res_o.lvl,
                                 res_o.bin, ok ? "ok" : "mismatch");
                    end
                end
                hold = res_valid_o && !res_ready_i;
                held = res_o;
            end
        end
    end

    initial
    begin
        int cycles;
        cycles = 0;
        forever
        begin
            @(posedge clk);
            cycles++;
            if (cycles >= TIMEOUT_CYCLES)
            begin
                $display("Run hung, no completion after %0d cycles, %0d results missing",
                         cycles, exp_q.size());
                $display("CHECKS FAILED");
                $finish;
            end
        end
    end

    initial
    begin
        bkt_res_t exp;
        bit       ok;
        rst         = 1'b0;
        cmd_valid_i = 1'b0;
        cmd_i       = '0;
        load_table();
        repeat (2) @(negedge clk);
        rst = 1'b1;
        @(negedge clk);
        check_ready(cmd_ready_o, 1'b1, ok);
        if (ok)
            pass_cnt++;
        else
            fail_cnt++;
        $display("Reset: cmd_ready_o=%0b %s", cmd_ready_o, ok ? "ok" : "mismatch");
        for (int i = 0; i < N_CMDS; i++)
        begin
            cmd_i       = cmd_table[i];
            cmd_valid_i = 1'b1;
            if (cmd_table[i].op == OP_FIND)
            begin
                predict_find(cmd_table[i], exp);
                exp_q.push_back(exp);
                idx_q.push_back(i);
                find_cnt++;
            end
            else
                shadow[cmd_table[i].lvl] = '{bin: cmd_table[i].bin, has_bkt: 1'b0};
            while (!cmd_ready_o)                 // FIFO full, hold the command
            begin
                stall_cnt++;
                @(negedge clk);
            end
            @(negedge clk);
            if (cmd_table[i].op == OP_PUSH)
                $display("cmd %0d PUSH lvl %0d bin %02h accepted",
                         i, cmd_table[i].lvl, cmd_table[i].bin);
        end
        cmd_valid_i = 1'b0;
        while (res_cnt < find_cnt)
            @(negedge clk);
        repeat (20) @(negedge clk);              // Catch stray results
        if (stall_cnt == 0)
        begin
            $display("cmd_ready_o never went low, the full FIFO was never reached");
            fail_cnt++;
        end
        $display("Done: %0d passed, %0d failed, cmd_ready_o low for %0d cycles",
                 pass_cnt, fail_cnt, stall_cnt);
        if (fail_cnt == 0 && res_cnt == find_cnt)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule

//--- bkt_engine.f
design/bkt_pkg.sv
design/bkt_cmd_fifo.sv
design/lvl_state_ram.sv
design/bkt_lvl_finder.sv
design/bkt_engine_top.sv
tb/bkt_engine_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the backtrack engine testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary -j 0 -f bkt_engine.f --top-module bkt_engine_tb -o bkt_engine_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/bkt_engine_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "CHECKS FAILED" "$LOG"; then
    exit 1
fi
exit 0
